//--- include/axi_bridge_settings.svh
`ifndef AXI_BRIDGE_SETTINGS_SVH
`define AXI_BRIDGE_SETTINGS_SVH

// byte address width on the AXI side
`define AXI_ADDR_W 32

// one AXI beat, one cache word
`define AXI_DATA_W 32

// beats per cache line, one INCR burst
`define LINE_WORDS 4

// full line as the caches see it
`define LINE_W 128

// width of arid
`define AXI_ID_W 4

// read ids per requester
`define ICACHE_ARID 0
`define DCACHE_ARID 1

`endif

//--- hw/axi_bridge_pkg.sv
`include "axi_bridge_settings.svh"

package axi_bridge_pkg;

    // byte address
    typedef logic [`AXI_ADDR_W-1:0] addr_t;

    // one beat on r or w
    typedef logic [`AXI_DATA_W-1:0] word_t;

    // cache line, word 0 in the low bits
    typedef logic [`LINE_W-1:0] line_t;

    // arid value
    typedef logic [`AXI_ID_W-1:0] axi_id_t;

    // beat position inside a line
    typedef logic [$clog2(`LINE_WORDS)-1:0] beat_idx_t;

    // refill engine states
    typedef enum logic [1:0] {REFILL_IDLE, REFILL_AR, REFILL_BEAT} refill_state_e;

    // write-back engine states
    typedef enum logic [1:0] {WB_IDLE, WB_AW, WB_BEAT, WB_RESP} wb_state_e;

endpackage

//--- hw/line_refill_engine.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module line_refill_engine
    import axi_bridge_pkg::*;
#(
    // read id carried on every AR of this engine
    parameter axi_id_t REFILL_ID = '0
) (
    input  logic    clk,
    input  logic    resetn,
    // cache side
    input  logic    i_rd_req,
    input  addr_t   i_rd_addr,
    output logic    o_rd_rdy,
    output logic    o_ret_valid,
    output line_t   o_ret_data,
    // AR toward the arbiter
    output axi_id_t o_arid,
    output addr_t   o_araddr,
    output logic    o_arvalid,
    input  logic    i_arready,
    // R from the arbiter, data straight from the bus
    input  logic    i_rvalid,
    input  word_t   i_rdata,
    output logic    o_rready
);

    // index of the final beat in a line
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`LINE_WORDS - 1);

    refill_state_e state_q;
    beat_idx_t     beat_q;
    addr_t         addr_q;
    line_t         line_q;
    logic          ret_valid_q;

    // request taken only while idle
    assign o_rd_rdy = (state_q == REFILL_IDLE);

    // AR held from the cycle after acceptance up to its transfer
    assign o_arid    = REFILL_ID;
    assign o_araddr  = addr_q;
    assign o_arvalid = (state_q == REFILL_AR);

    // accept beats for the whole burst
    assign o_rready = (state_q == REFILL_BEAT);

    assign o_ret_valid = ret_valid_q;
    assign o_ret_data  = line_q;

    // control FSM and beat counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q     <= REFILL_IDLE;
            beat_q      <= '0;
            ret_valid_q <= 1'b0;
        end else begin
            // ret_valid lasts one cycle only
            ret_valid_q <= 1'b0;
            case (state_q)
                REFILL_IDLE: begin
                    if (i_rd_req) begin
                        state_q <= REFILL_AR;
                    end
                end
                REFILL_AR: begin
                    if (i_arready) begin
                        state_q <= REFILL_BEAT;
                        beat_q  <= '0;
                    end
                end
                REFILL_BEAT: begin
                    // stall here as long as rvalid stays low
                    if (i_rvalid) begin
                        beat_q <= beat_q + 1'b1;
                        if (beat_q == LAST_BEAT) begin
                            state_q     <= REFILL_IDLE;
                            ret_valid_q <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= REFILL_IDLE;
                end
            endcase
        end
    end

    // address latch on acceptance
    always_ff @(posedge clk) begin
        if (o_rd_rdy && i_rd_req) begin
            addr_q <= i_rd_addr;
        end
    end

    // line assembly, lowest word first
    always_ff @(posedge clk) begin
        if (o_rready && i_rvalid) begin
            line_q[beat_q*`AXI_DATA_W +: `AXI_DATA_W] <= i_rdata;
        end
    end

endmodule

//--- hw/line_writeback_engine.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module line_writeback_engine
    import axi_bridge_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    // data cache side
    input  logic  i_wr_req,
    input  addr_t i_wr_addr,
    input  line_t i_wr_data,
    output logic  o_wr_rdy,
    // AW channel
    output addr_t o_awaddr,
    output logic  o_awvalid,
    input  logic  i_awready,
    // W channel
    output word_t o_wdata,
    output logic  o_wlast,
    output logic  o_wvalid,
    input  logic  i_wready,
    // B channel
    input  logic  i_bvalid,
    output logic  o_bready
);

    // index of the final beat in a line
    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`LINE_WORDS - 1);

    wb_state_e state_q;
    beat_idx_t beat_q;
    addr_t     addr_q;
    line_t     line_q;

    // free only when fully idle, B included
    assign o_wr_rdy = (state_q == WB_IDLE);

    // address phase
    assign o_awaddr  = addr_q;
    assign o_awvalid = (state_q == WB_AW);

    // current word sliced out of the latched line
    assign o_wdata  = line_q[beat_q*`AXI_DATA_W +: `AXI_DATA_W];
    assign o_wvalid = (state_q == WB_BEAT);

    // wlast from state and index alone, stable while wready is low
    assign o_wlast = (state_q == WB_BEAT) && (beat_q == LAST_BEAT);

    // response phase
    assign o_bready = (state_q == WB_RESP);

    // control FSM and beat counter
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= WB_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WB_IDLE: begin
                    if (i_wr_req) begin
                        state_q <= WB_AW;
                    end
                end
                WB_AW: begin
                    if (i_awready) begin
                        state_q <= WB_BEAT;
                        beat_q  <= '0;
                    end
                end
                WB_BEAT: begin
                    if (i_wready) begin
                        beat_q <= beat_q + 1'b1;
                        // last W accepted, wait for B
                        if (beat_q == LAST_BEAT) begin
                            state_q <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    // bresp not checked
                    if (i_bvalid) begin
                        state_q <= WB_IDLE;
                    end
                end
                default: begin
                    state_q <= WB_IDLE;
                end
            endcase
        end
    end

    // address and line captured together on acceptance
    always_ff @(posedge clk) begin
        if (o_wr_rdy && i_wr_req) begin
            addr_q <= i_wr_addr;
            line_q <= i_wr_data;
        end
    end

endmodule

//--- hw/read_channel_arbiter.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module read_channel_arbiter
    import axi_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    // instruction refill engine
    input  axi_id_t i_ic_arid,
    input  addr_t   i_ic_araddr,
    input  logic    i_ic_arvalid,
    input  logic    i_ic_rready,
    output logic    o_ic_arready,
    output logic    o_ic_rvalid,
    // data refill engine
    input  axi_id_t i_dc_arid,
    input  addr_t   i_dc_araddr,
    input  logic    i_dc_arvalid,
    input  logic    i_dc_rready,
    output logic    o_dc_arready,
    output logic    o_dc_rvalid,
    // shared AXI read channel
    output axi_id_t o_arid,
    output addr_t   o_araddr,
    output logic    o_arvalid,
    input  logic    i_arready,
    input  logic    i_rvalid,
    output logic    o_rready
);

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`LINE_WORDS - 1);

    // burst in flight on R
    logic      busy_q;
    // AR shown but not yet taken, selection frozen
    logic      ar_hold_q;
    // selected side, data cache when set
    logic      owner_dc_q;
    beat_idx_t r_cnt_q;
    logic      sel_dc;
    logic      r_fire;

    // fixed priority to dcache while the choice is open
    assign sel_dc = (busy_q || ar_hold_q) ? owner_dc_q : i_dc_arvalid;

    // AR forwarded only while no burst runs
    assign o_arvalid = !busy_q && (sel_dc ? i_dc_arvalid : i_ic_arvalid);
    assign o_arid    = sel_dc ? i_dc_arid : i_ic_arid;
    assign o_araddr  = sel_dc ? i_dc_araddr : i_ic_araddr;

    // loser sees arready low
    assign o_dc_arready = !busy_q && sel_dc && i_arready;
    assign o_ic_arready = !busy_q && !sel_dc && i_arready;

    // R steered to the owner only
    assign o_rready    = busy_q && (owner_dc_q ? i_dc_rready : i_ic_rready);
    assign o_dc_rvalid = busy_q && owner_dc_q && i_rvalid;
    assign o_ic_rvalid = busy_q && !owner_dc_q && i_rvalid;
    assign r_fire      = i_rvalid && o_rready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q     <= 1'b0;
            ar_hold_q  <= 1'b0;
            owner_dc_q <= 1'b0;
            r_cnt_q    <= '0;
        end else if (o_arvalid && i_arready) begin
            // owner latched on the AR transfer
            busy_q     <= 1'b1;
            ar_hold_q  <= 1'b0;
            owner_dc_q <= sel_dc;
            r_cnt_q    <= '0;
        end else if (o_arvalid) begin
            // keep araddr and arid stable until taken
            ar_hold_q  <= 1'b1;
            owner_dc_q <= sel_dc;
        end else if (r_fire) begin
            r_cnt_q <= r_cnt_q + 1'b1;
            // channel free after the owner's fourth beat
            if (r_cnt_q == LAST_BEAT) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

//--- hw/axi_bridge.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module axi_bridge
    import axi_bridge_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    // instruction cache refill
    input  logic    i_ic_rd_req,
    input  addr_t   i_ic_rd_addr,
    output logic    o_ic_rd_rdy,
    output logic    o_ic_ret_valid,
    output line_t   o_ic_ret_data,
    // data cache refill
    input  logic    i_dc_rd_req,
    input  addr_t   i_dc_rd_addr,
    output logic    o_dc_rd_rdy,
    output logic    o_dc_ret_valid,
    output line_t   o_dc_ret_data,
    // data cache write-back
    input  logic    i_dc_wr_req,
    input  addr_t   i_dc_wr_addr,
    input  line_t   i_dc_wr_data,
    output logic    o_dc_wr_rdy,
    // AXI read address and data
    output axi_id_t o_arid,
    output addr_t   o_araddr,
    output logic    o_arvalid,
    input  logic    i_arready,
    input  logic    i_rvalid,
    input  word_t   i_rdata,
    output logic    o_rready,
    // AXI write address, data and response
    output addr_t   o_awaddr,
    output logic    o_awvalid,
    input  logic    i_awready,
    output word_t   o_wdata,
    output logic    o_wlast,
    output logic    o_wvalid,
    input  logic    i_wready,
    input  logic    i_bvalid,
    output logic    o_bready
);

    // icache engine to arbiter
    axi_id_t ic_arid;
    addr_t   ic_araddr;
    logic    ic_arvalid;
    logic    ic_arready;
    logic    ic_rvalid;
    logic    ic_rready;

    // dcache engine to arbiter
    axi_id_t dc_arid;
    addr_t   dc_araddr;
    logic    dc_arvalid;
    logic    dc_arready;
    logic    dc_rvalid;
    logic    dc_rready;

    line_refill_engine #(
        .REFILL_ID (axi_id_t'(`ICACHE_ARID))
    ) u_ic_refill (
        .clk         (clk),
        .resetn      (resetn),
        .i_rd_req    (i_ic_rd_req),
        .i_rd_addr   (i_ic_rd_addr),
        .o_rd_rdy    (o_ic_rd_rdy),
        .o_ret_valid (o_ic_ret_valid),
        .o_ret_data  (o_ic_ret_data),
        .o_arid      (ic_arid),
        .o_araddr    (ic_araddr),
        .o_arvalid   (ic_arvalid),
        .i_arready   (ic_arready),
        .i_rvalid    (ic_rvalid),
        .i_rdata     (i_rdata),
        .o_rready    (ic_rready)
    );

    line_refill_engine #(
        .REFILL_ID (axi_id_t'(`DCACHE_ARID))
    ) u_dc_refill (
        .clk         (clk),
        .resetn      (resetn),
        .i_rd_req    (i_dc_rd_req),
        .i_rd_addr   (i_dc_rd_addr),
        .o_rd_rdy    (o_dc_rd_rdy),
        .o_ret_valid (o_dc_ret_valid),
        .o_ret_data  (o_dc_ret_data),
        .o_arid      (dc_arid),
        .o_araddr    (dc_araddr),
        .o_arvalid   (dc_arvalid),
        .i_arready   (dc_arready),
        .i_rvalid    (dc_rvalid),
        .i_rdata     (i_rdata),
        .o_rready    (dc_rready)
    );

    // write path runs beside the reads, no arbitration
    line_writeback_engine u_dc_writeback (
        .clk       (clk),
        .resetn    (resetn),
        .i_wr_req  (i_dc_wr_req),
        .i_wr_addr (i_dc_wr_addr),
        .i_wr_data (i_dc_wr_data),
        .o_wr_rdy  (o_dc_wr_rdy),
        .o_awaddr  (o_awaddr),
        .o_awvalid (o_awvalid),
        .i_awready (i_awready),
        .o_wdata   (o_wdata),
        .o_wlast   (o_wlast),
        .o_wvalid  (o_wvalid),
        .i_wready  (i_wready),
        .i_bvalid  (i_bvalid),
        .o_bready  (o_bready)
    );

    read_channel_arbiter u_rd_arb (
        .clk          (clk),
        .resetn       (resetn),
        .i_ic_arid    (ic_arid),
        .i_ic_araddr  (ic_araddr),
        .i_ic_arvalid (ic_arvalid),
        .i_ic_rready  (ic_rready),
        .o_ic_arready (ic_arready),
        .o_ic_rvalid  (ic_rvalid),
        .i_dc_arid    (dc_arid),
        .i_dc_araddr  (dc_araddr),
        .i_dc_arvalid (dc_arvalid),
        .i_dc_rready  (dc_rready),
        .o_dc_arready (dc_arready),
        .o_dc_rvalid  (dc_rvalid),
        .o_arid       (o_arid),
        .o_araddr     (o_araddr),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready)
    );

endmodule

//--- verif/axi_mem_model.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module axi_mem_model
    import axi_bridge_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    // read address and data
    input  addr_t i_araddr,
    input  logic  i_arvalid,
    output logic  o_arready,
    output logic  o_rvalid,
    output word_t o_rdata,
    input  logic  i_rready,
    // write address, data and response
    input  addr_t i_awaddr,
    input  logic  i_awvalid,
    output logic  o_awready,
    input  word_t i_wdata,
    input  logic  i_wvalid,
    output logic  o_wready,
    output logic  o_bvalid,
    input  logic  i_bready,
    // a handshake partner never answered
    output logic  o_stall
);

    localparam int HANDSHAKE_LIMIT = 200;

    word_t       mem [0:255];
    logic [31:0] rd_seed;
    logic [31:0] wr_seed;
    logic        rd_stall;
    logic        wr_stall;

    assign o_stall = rd_stall || wr_stall;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // 0 to 3 falling edges, drawn from the given stream
    task automatic random_delay(inout logic [31:0] seed);
        seed = lcg_next(seed);
        repeat (seed[17:16]) @(negedge clk);
    endtask

    // read side, one 4-beat burst at a time
    initial begin
        int          n;
        int          i;
        logic [7:0]  idx;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rdata   = '0;
        rd_stall  = 1'b0;
        rd_seed   = 32'h971a;
        forever begin
            @(negedge clk);
            if (resetn && i_arvalid) begin
                random_delay(rd_seed);
                o_arready = 1'b1;
                idx = i_araddr[9:2];
                @(negedge clk);
                o_arready = 1'b0;
                for (i = 0; i < 4; i++) begin
                    random_delay(rd_seed);
                    o_rvalid = 1'b1;
                    o_rdata  = mem[idx + 8'(i)];
                    n = 0;
                    @(posedge clk);
                    while (!i_rready) begin
                        n++;
                        if (n > HANDSHAKE_LIMIT) begin
                            rd_stall = 1'b1;
                        end
                        @(posedge clk);
                    end
                    @(negedge clk);
                    o_rvalid = 1'b0;
                end
            end
        end
    end

    // write side, also owns the memory contents
    initial begin
        int          n;
        int          b;
        logic [7:0]  widx;
        for (b = 0; b < 256; b++) begin
            mem[b] = b ^ 32'h5a5a0000;
        end
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        wr_stall  = 1'b0;
        wr_seed   = lcg_next(32'h971a);
        forever begin
            @(negedge clk);
            if (resetn && i_awvalid) begin
                random_delay(wr_seed);
                o_awready = 1'b1;
                widx = i_awaddr[9:2];
                @(negedge clk);
                o_awready = 1'b0;
                for (b = 0; b < 4; b++) begin
                    random_delay(wr_seed);
                    o_wready = 1'b1;
                    n = 0;
                    @(posedge clk);
                    while (!i_wvalid) begin
                        n++;
                        if (n > HANDSHAKE_LIMIT) begin
                            wr_stall = 1'b1;
                        end
                        @(posedge clk);
                    end
                    mem[widx + 8'(b)] = i_wdata;
                    @(negedge clk);
                    o_wready = 1'b0;
                end
                // write response after the last beat
                random_delay(wr_seed);
                o_bvalid = 1'b1;
                n = 0;
                @(posedge clk);
                while (!i_bready) begin
                    n++;
                    if (n > HANDSHAKE_LIMIT) begin
                        wr_stall = 1'b1;
                    end
                    @(posedge clk);
                end
                @(negedge clk);
                o_bvalid = 1'b0;
            end
        end
    end

endmodule

//--- verif/tb_axi_bridge.sv
`timescale 1ns/1ps
`include "axi_bridge_settings.svh"

module tb_axi_bridge
    import axi_bridge_pkg::*;
;

    localparam int WAIT_LIMIT = 500;

    logic clk;
    logic resetn;
    logic i_ic_rd_req, i_dc_rd_req, i_dc_wr_req;
    addr_t i_ic_rd_addr, i_dc_rd_addr, i_dc_wr_addr;
    line_t i_dc_wr_data;
    logic o_ic_rd_rdy, o_ic_ret_valid, o_dc_rd_rdy, o_dc_ret_valid, o_dc_wr_rdy;
    line_t o_ic_ret_data, o_dc_ret_data;
    axi_id_t o_arid;
    addr_t o_araddr, o_awaddr;
    logic o_arvalid, o_rready, o_awvalid, o_wlast, o_wvalid, o_bready;
    word_t o_wdata, rdata;
    logic arready, rvalid, awready, wready, bvalid, mem_stall;

    // scoreboard state updated on rising edges
    word_t ref_mem [0:255];
    logic ic_busy, dc_busy, wb_busy, seen_req, contend, aw_seen;
    logic [2:0] w_cnt;
    addr_t ic_addr_q, dc_addr_q, wb_addr_q;
    line_t exp_ic_line, exp_dc_line, exp_wb_line;
    word_t exp_wdata;
    logic ic_accept, dc_accept, wb_accept, ar_fire, aw_fire, w_fire;

    axi_bridge uut (
        .clk(clk), .resetn(resetn),
        .i_ic_rd_req(i_ic_rd_req), .i_ic_rd_addr(i_ic_rd_addr), .o_ic_rd_rdy(o_ic_rd_rdy),
        .o_ic_ret_valid(o_ic_ret_valid), .o_ic_ret_data(o_ic_ret_data),
        .i_dc_rd_req(i_dc_rd_req), .i_dc_rd_addr(i_dc_rd_addr), .o_dc_rd_rdy(o_dc_rd_rdy),
        .o_dc_ret_valid(o_dc_ret_valid), .o_dc_ret_data(o_dc_ret_data),
        .i_dc_wr_req(i_dc_wr_req), .i_dc_wr_addr(i_dc_wr_addr),
        .i_dc_wr_data(i_dc_wr_data), .o_dc_wr_rdy(o_dc_wr_rdy),
        .o_arid(o_arid), .o_araddr(o_araddr), .o_arvalid(o_arvalid), .i_arready(arready),
        .i_rvalid(rvalid), .i_rdata(rdata), .o_rready(o_rready),
        .o_awaddr(o_awaddr), .o_awvalid(o_awvalid), .i_awready(awready),
        .o_wdata(o_wdata), .o_wlast(o_wlast), .o_wvalid(o_wvalid), .i_wready(wready),
        .i_bvalid(bvalid), .o_bready(o_bready)
    );

    axi_mem_model u_mem (
        .clk(clk), .resetn(resetn),
        .i_araddr(o_araddr), .i_arvalid(o_arvalid), .o_arready(arready),
        .o_rvalid(rvalid), .o_rdata(rdata), .i_rready(o_rready),
        .i_awaddr(o_awaddr), .i_awvalid(o_awvalid), .o_awready(awready),
        .i_wdata(o_wdata), .i_wvalid(o_wvalid), .o_wready(wready),
        .o_bvalid(bvalid), .i_bready(o_bready), .o_stall(mem_stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign ic_accept = i_ic_rd_req && o_ic_rd_rdy;
    assign dc_accept = i_dc_rd_req && o_dc_rd_rdy;
    assign wb_accept = i_dc_wr_req && o_dc_wr_rdy;
    assign ar_fire   = o_arvalid && arready;
    assign aw_fire   = o_awvalid && awready;
    assign w_fire    = o_wvalid && wready;
    // word the current W beat should carry
    assign exp_wdata = exp_wb_line[32*w_cnt[1:0] +: 32];

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input line_t got, input line_t exp);
        $display("** Error: %s = %h, expected %h", name, got, exp);
        abort_run("value mismatch");
    endtask

    // reference line with word 0 in the low bits
    function automatic line_t ref_line(input addr_t a);
        logic [7:0] w;
        w = a[9:2];
        return {ref_mem[w + 8'd3], ref_mem[w + 8'd2], ref_mem[w + 8'd1], ref_mem[w]};
    endfunction

    always @(posedge clk) begin
        if (!resetn) begin
            for (int k = 0; k < 256; k++) begin
                ref_mem[k] <= k ^ 32'h5a5a0000;
            end
            {ic_busy, dc_busy, wb_busy, seen_req, contend, aw_seen} <= '0;
            w_cnt <= '0;
        end else begin
            if (i_ic_rd_req || i_dc_rd_req || i_dc_wr_req) begin
                seen_req <= 1'b1;
            end
            if (ic_accept) begin
                ic_busy     <= 1'b1;
                ic_addr_q   <= i_ic_rd_addr;
                exp_ic_line <= ref_line(i_ic_rd_addr);
            end else if (o_ic_ret_valid) begin
                ic_busy <= 1'b0;
            end
            if (dc_accept) begin
                dc_busy     <= 1'b1;
                dc_addr_q   <= i_dc_rd_addr;
                exp_dc_line <= ref_line(i_dc_rd_addr);
            end else if (o_dc_ret_valid) begin
                dc_busy <= 1'b0;
            end
            // both sides taken on one edge
            if (ic_accept && dc_accept) begin
                contend <= 1'b1;
            end else if (ar_fire) begin
                contend <= 1'b0;
            end
            if (wb_accept) begin
                wb_busy     <= 1'b1;
                wb_addr_q   <= i_dc_wr_addr;
                exp_wb_line <= i_dc_wr_data;
                w_cnt       <= '0;
                aw_seen     <= 1'b0;
                for (int k = 0; k < 4; k++) begin
                    ref_mem[i_dc_wr_addr[9:2] + 8'(k)] <= i_dc_wr_data[32*k +: 32];
                end
            end else begin
                if (aw_fire) begin
                    aw_seen <= 1'b1;
                end
                if (w_fire) begin
                    w_cnt <= w_cnt + 1'b1;
                end
                if (o_dc_wr_rdy) begin
                    wb_busy <= 1'b0;
                end
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!resetn)
        !seen_req |-> (o_ic_rd_rdy && o_dc_rd_rdy && o_dc_wr_rdy && !o_arvalid && !o_rready
            && !o_awvalid && !o_wvalid && !o_wlast && !o_bready
            && !o_ic_ret_valid && !o_dc_ret_valid))
        else abort_run("outputs not idle after reset");
    a_ic_pulse: assert property (@(posedge clk) disable iff (!resetn)
        o_ic_ret_valid |=> !o_ic_ret_valid)
        else abort_run("icache ret_valid longer than one cycle");
    a_dc_pulse: assert property (@(posedge clk) disable iff (!resetn)
        o_dc_ret_valid |=> !o_dc_ret_valid)
        else abort_run("dcache ret_valid longer than one cycle");
    a_ic_data: assert property (@(posedge clk) disable iff (!resetn)
        o_ic_ret_valid |-> (o_ic_ret_data == exp_ic_line))
        else report_mismatch("o_ic_ret_data", $sampled(o_ic_ret_data), $sampled(exp_ic_line));
    a_dc_data: assert property (@(posedge clk) disable iff (!resetn)
        o_dc_ret_valid |-> (o_dc_ret_data == exp_dc_line))
        else report_mismatch("o_dc_ret_data", $sampled(o_dc_ret_data), $sampled(exp_dc_line));
    // ret_valid only within a refill and rdy back high only with the return
    a_ic_rdy: assert property (@(posedge clk) disable iff (!resetn)
        (ic_busy || o_ic_ret_valid) |-> (ic_busy && (o_ic_rd_rdy == o_ic_ret_valid)))
        else abort_run("icache rdy or ret_valid wrong around a refill");
    a_dc_rdy: assert property (@(posedge clk) disable iff (!resetn)
        (dc_busy || o_dc_ret_valid) |-> (dc_busy && (o_dc_rd_rdy == o_dc_ret_valid)))
        else abort_run("dcache rdy or ret_valid wrong around a refill");
    a_ar_id: assert property (@(posedge clk) disable iff (!resetn)
        ar_fire |-> ((o_arid == axi_id_t'(`DCACHE_ARID) && dc_busy && o_araddr == dc_addr_q)
            || (o_arid == axi_id_t'(`ICACHE_ARID) && ic_busy && o_araddr == ic_addr_q)))
        else abort_run("AR transfer with an id or address of no pending refill");
    a_priority: assert property (@(posedge clk) disable iff (!resetn)
        (ar_fire && contend) |-> (o_arid == axi_id_t'(`DCACHE_ARID)))
        else report_mismatch("o_arid", line_t'($sampled(o_arid)), line_t'(`DCACHE_ARID));
    a_aw_addr: assert property (@(posedge clk) disable iff (!resetn)
        aw_fire |-> (o_awaddr == wb_addr_q))
        else report_mismatch("o_awaddr", line_t'($sampled(o_awaddr)),
            line_t'($sampled(wb_addr_q)));
    a_aw_once: assert property (@(posedge clk) disable iff (!resetn)
        aw_fire |-> (wb_busy && !aw_seen))
        else abort_run("unexpected extra AW transfer");
    // W valid only between the AW transfer and the fourth beat
    a_w_order: assert property (@(posedge clk) disable iff (!resetn)
        o_wvalid |-> (aw_seen && w_cnt < 3'd4))
        else abort_run("W valid before AW or beyond four beats");
    a_w_data: assert property (@(posedge clk) disable iff (!resetn)
        w_fire |-> (o_wdata == exp_wdata))
        else report_mismatch("o_wdata", line_t'($sampled(o_wdata)),
            line_t'($sampled(exp_wdata)));
    a_w_last: assert property (@(posedge clk) disable iff (!resetn)
        o_wvalid |-> (o_wlast == (w_cnt == 3'd3)))
        else report_mismatch("o_wlast", line_t'($sampled(o_wlast)),
            line_t'($sampled(w_cnt) == 3'd3));
    // engine free again only after all four beats
    a_wb_done: assert property (@(posedge clk) disable iff (!resetn)
        (wb_busy && o_dc_wr_rdy) |-> (aw_seen && w_cnt == 3'd4))
        else abort_run("write-back finished without one AW and four W beats");
    a_mem: assert property (@(posedge clk) disable iff (!resetn) !mem_stall)
        else abort_run("memory model handshake timed out");

    task automatic refill(input logic dc, input addr_t addr);
        int n;
        @(negedge clk);
        if (dc) begin
            i_dc_rd_req  = 1'b1;
            i_dc_rd_addr = addr;
        end else begin
            i_ic_rd_req  = 1'b1;
            i_ic_rd_addr = addr;
        end
        n = 0;
        @(posedge clk);
        while (!(dc ? o_dc_rd_rdy : o_ic_rd_rdy)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("refill request was never accepted");
            end else begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        if (dc) begin
            i_dc_rd_req = 1'b0;
        end else begin
            i_ic_rd_req = 1'b0;
        end
        n = 0;
        @(posedge clk);
        while (!(dc ? o_dc_ret_valid : o_ic_ret_valid)) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("refill line never returned");
            end else begin
                @(posedge clk);
            end
        end
    endtask

    task automatic write_back(input addr_t addr, input line_t line);
        int n;
        @(negedge clk);
        i_dc_wr_req  = 1'b1;
        i_dc_wr_addr = addr;
        i_dc_wr_data = line;
        n = 0;
        @(posedge clk);
        while (!o_dc_wr_rdy) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("write-back request was never accepted");
            end else begin
                @(posedge clk);
            end
        end
        @(negedge clk);
        i_dc_wr_req = 1'b0;
        // engine idle again once B is taken
        n = 0;
        @(posedge clk);
        while (!o_dc_wr_rdy) begin
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("write-back never completed");
            end else begin
                @(posedge clk);
            end
        end
    endtask

    initial begin
        resetn       = 1'b0;
        i_ic_rd_req  = 1'b0;
        i_dc_rd_req  = 1'b0;
        i_dc_wr_req  = 1'b0;
        i_ic_rd_addr = '0;
        i_dc_rd_addr = '0;
        i_dc_wr_addr = '0;
        i_dc_wr_data = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        repeat (4) @(posedge clk);
        // single refills on each side
        refill(1'b0, 32'h0000_0040);
        refill(1'b1, 32'h0000_0080);
        // contention where dcache goes first
        fork
            refill(1'b0, 32'h0000_0100);
            refill(1'b1, 32'h0000_0200);
        join
        write_back(32'h0000_0300, 128'hd00d0003_d00d0002_d00d0001_d00d0000);
        refill(1'b1, 32'h0000_0300);
        // write-back with an icache refill alongside
        fork
            write_back(32'h0000_0340, 128'hbeef0013_beef0012_beef0011_beef0010);
            refill(1'b0, 32'h0000_0380);
        join
        refill(1'b1, 32'h0000_0340);
        repeat (4) @(posedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- axi_bridge.f
+incdir+include
hw/axi_bridge_pkg.sv
hw/line_refill_engine.sv
hw/line_writeback_engine.sv
hw/read_channel_arbiter.sv
hw/axi_bridge.sv
verif/axi_mem_model.sv
verif/tb_axi_bridge.sv

//--- Makefile
TOP := tb_axi_bridge

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f axi_bridge.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
